// ==== hw/tracker_pkg.sv ====
package tracker_pkg;

	typedef logic [7:0]  byte_t;     // buffer byte, field byte
	typedef logic [31:0] word_t;     // main memory word
	typedef logic [17:0] mem_addr_t;
	typedef logic [18:0] ptr_t;      // pointer table entry
	typedef logic [4:0]  ptr_addr_t; // table index, blob count
	typedef logic [5:0]  buf_addr_t; // 64 byte packet
	typedef logic [7:0]  color_t;    // byte 0 of word one
	typedef logic [3:0]  slot_t;     // record index in layout

	localparam color_t COLOR_RED    = 8'd0;
	localparam color_t COLOR_ORANGE = 8'd1;
	localparam color_t COLOR_YELLOW = 8'd2;
	localparam color_t COLOR_GREEN  = 8'd3;
	localparam color_t COLOR_BLUE   = 8'd4;
	localparam color_t COLOR_PURPLE = 8'd5;

	localparam byte_t MARK_BYTE     = 8'd176;
	localparam byte_t LF_BYTE       = 8'd10;
	localparam byte_t CR_BYTE       = 8'd13;
	localparam byte_t VERSION_THREE = 8'd1;
	localparam byte_t VERSION_SIX   = 8'd2;

	localparam ptr_t PTR_END = 19'h7fff; // at or above ends the table

	// n colours per rank
	function automatic slot_t num_colors(logic six);
		return six ? slot_t'(6) : slot_t'(3);
	endfunction

	function automatic logic color_ok(color_t c, logic six);
		if (six)
			return c <= COLOR_PURPLE;
		return (c == COLOR_RED) || (c == COLOR_GREEN) || (c == COLOR_BLUE); // r g b only
	endfunction

	// position in the mode's colour list
	function automatic slot_t color_index(color_t c, logic six);
		if (six)
			return slot_t'(c);
		case (c)
			COLOR_GREEN: return slot_t'(1);
			COLOR_BLUE:  return slot_t'(2);
			default:     return slot_t'(0);
		endcase
	endfunction

	// k = (rank - 1) * n + c
	function automatic slot_t record_slot(logic rank2, color_t c, logic six);
		return (rank2 ? num_colors(six) : slot_t'(0)) + color_index(c, six);
	endfunction

	// idx 0 x, 1 y, 2 size hi, 3 size lo
	function automatic buf_addr_t field_addr(slot_t k, logic [1:0] idx, logic six);
		buf_addr_t a;
		a = buf_addr_t'(2) + buf_addr_t'({k, 1'b0});
		if (idx[1])
			a = a + buf_addr_t'({num_colors(six), 2'b00}); // size block after 4n centroid bytes
		return a + buf_addr_t'(idx[0]);
	endfunction

	function automatic buf_addr_t lf_addr(logic six);
		return buf_addr_t'(2) + buf_addr_t'({num_colors(six), 3'b000}); // 2 + 8n with cr next
	endfunction

	function automatic byte_t version_byte(logic six);
		return six ? VERSION_SIX : VERSION_THREE;
	endfunction

endpackage

// ==== hw/blob_fetch_decode.sv ====
`timescale 1ns/1ps

module blob_fetch_decode #(
	parameter int RANK_SIZE = 6,  // table slots per rank
	parameter int MAX_BLOBS = 19  // table depth
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pause,
	input  logic                  start,
	input  logic                  six_color,
	input  tracker_pkg::ptr_addr_t valid_blobs,
	output tracker_pkg::ptr_addr_t ptr_addr,
	input  tracker_pkg::ptr_t      ptr,
	output tracker_pkg::mem_addr_t mem_addr,
	input  tracker_pkg::word_t     mem_data,
	output logic                  blob_valid,
	output tracker_pkg::slot_t     slot,
	output tracker_pkg::byte_t     x_byte,
	output tracker_pkg::byte_t     y_byte,
	output tracker_pkg::byte_t     size_hi,
	output tracker_pkg::byte_t     size_lo,
	output logic                  fetch_end
);
	import tracker_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_PTR,  // pointer wait
		S_W1,   // word one wait
		S_W2,   // word two wait
		S_END
	} state_t;

	state_t    state;
	logic      lat;      // issued address sampled so data is on the bus
	logic      six_q;    // mode for this run
	ptr_addr_t count_q;  // valid_blobs at start
	color_t    color_q;  // from word one

	logic [5:0] next_idx; // one wider so no wrap at the table end
	logic       last_blob;
	logic       rank_ok;
	logic       rank2;
	logic       store;

	assign next_idx  = {1'b0, ptr_addr} + 6'd1;
	assign last_blob = (next_idx >= 6'(count_q)) || (int'(next_idx) >= MAX_BLOBS);
	assign rank_ok   = int'(ptr_addr) < 2 * RANK_SIZE; // ranks 1 and 2 only
	assign rank2     = int'(ptr_addr) >= RANK_SIZE;
	assign store     = rank_ok && color_ok(color_q, six_q);

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= S_IDLE;
			lat        <= 1'b0;
			six_q      <= 1'b0;
			count_q    <= '0;
			ptr_addr   <= '0;
			mem_addr   <= '0;
			blob_valid <= 1'b0;
			fetch_end  <= 1'b0;
		end else if (!pause) begin // pause freezes everything including the strobes
			blob_valid <= 1'b0;
			fetch_end  <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						six_q    <= six_color;
						count_q  <= valid_blobs;
						ptr_addr <= '0;
						lat      <= 1'b0;
						state    <= (valid_blobs == '0) ? S_END : S_PTR; // empty table
					end
				end
				S_PTR: begin
					if (!lat) begin
						lat <= 1'b1; // table latency
					end else begin
						lat <= 1'b0;
						if (ptr >= PTR_END) begin
							state <= S_END; // end marker in the table
						end else begin
							mem_addr <= ptr[17:0];
							state    <= S_W1;
						end
					end
				end
				S_W1: begin
					if (!lat) begin
						lat <= 1'b1;
					end else begin
						lat      <= 1'b0;
						color_q  <= mem_data[7:0];
						mem_addr <= mem_addr + mem_addr_t'(1); // word two
						state    <= S_W2;
					end
				end
				S_W2: begin
					if (!lat) begin
						lat <= 1'b1;
					end else begin
						lat <= 1'b0;
						if (store) begin
							blob_valid <= 1'b1;
							slot       <= record_slot(rank2, color_q, six_q);
							x_byte     <= mem_data[31:24];
							y_byte     <= mem_data[23:16];
							size_hi    <= mem_data[15:8];
							size_lo    <= mem_data[7:0];
						end
						// next table slot or done
						if (last_blob) begin
							state <= S_END;
						end else begin
							ptr_addr <= ptr_addr + ptr_addr_t'(1);
							state    <= S_PTR;
						end
					end
				end
				S_END: begin
					fetch_end <= 1'b1; // trails the last blob strobe
					state     <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== hw/record_writer.sv ====
`timescale 1ns/1ps

module record_writer #(
	parameter int RANK_SIZE = 6
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pause,
	input  logic                  start,
	input  logic                  six_color,
	input  logic                  blob_valid,
	input  tracker_pkg::slot_t     slot,
	input  tracker_pkg::byte_t     x_byte,
	input  tracker_pkg::byte_t     y_byte,
	input  tracker_pkg::byte_t     size_hi,
	input  tracker_pkg::byte_t     size_lo,
	input  logic                  fetch_end,
	output logic                  clear,
	output logic                  wr_en,
	output tracker_pkg::buf_addr_t wr_addr,
	output tracker_pkg::byte_t     wr_data,
	output logic                  done
);
	import tracker_pkg::*;

	typedef enum logic [2:0] {
		W_IDLE,
		W_VER,   // version byte
		W_WAIT,  // between records
		W_REC,   // bytes 1..3 of current record
		W_CR,
		W_DONE
	} state_t;

	state_t      state;
	logic        six_q;
	logic        end_seen;   // fetch_end came while busy
	logic        pend_valid; // one record parked
	logic [1:0]  byte_idx;
	slot_t       cur_slot;
	slot_t       pend_slot;
	byte_t [3:0] cur_field;  // [0] x .. [3] size lo
	byte_t [3:0] pend_field;

	byte_t [3:0] in_field;
	logic        in_ok;
	slot_t       src_slot;
	byte_t [3:0] src_field;
	logic        park;

	assign in_field  = {size_lo, size_hi, y_byte, x_byte};
	assign in_ok     = blob_valid && (int'(slot) < 2 * RANK_SIZE); // two ranks per layout
	// pending record goes first
	assign src_slot  = pend_valid ? pend_slot : slot;
	assign src_field = pend_valid ? pend_field : in_field;
	// a strobe served straight away only in W_WAIT with nothing parked
	assign park      = in_ok && (state != W_IDLE) && !(state == W_WAIT && !pend_valid);

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= W_IDLE;
			six_q      <= 1'b0;
			end_seen   <= 1'b0;
			pend_valid <= 1'b0;
			byte_idx   <= '0;
			clear      <= 1'b0;
			wr_en      <= 1'b0;
			done       <= 1'b0;
		end else begin
			clear <= 1'b0; // buffer side strobes stay single cycle under pause
			wr_en <= 1'b0;
			done  <= 1'b0;
			if (!pause) begin
				if (fetch_end)
					end_seen <= 1'b1;
				case (state)
					W_IDLE: begin
						if (start) begin
							clear      <= 1'b1; // drop stale bytes
							six_q      <= six_color;
							end_seen   <= 1'b0;
							pend_valid <= 1'b0;
							wr_en      <= 1'b1;
							wr_addr    <= '0;
							wr_data    <= MARK_BYTE;
							state      <= W_VER;
						end
					end
					W_VER: begin
						wr_en   <= 1'b1;
						wr_addr <= buf_addr_t'(1);
						wr_data <= version_byte(six_q);
						state   <= W_WAIT;
					end
					W_WAIT: begin
						if (pend_valid || in_ok) begin
							cur_slot   <= src_slot;
							cur_field  <= src_field;
							pend_valid <= 1'b0; // re-set below if another strobe lands
							wr_en      <= 1'b1; // x byte right away
							wr_addr    <= field_addr(src_slot, 2'd0, six_q);
							wr_data    <= src_field[0];
							byte_idx   <= 2'd1;
							state      <= W_REC;
						end else if (end_seen || fetch_end) begin
							end_seen <= 1'b0;
							wr_en    <= 1'b1;
							wr_addr  <= lf_addr(six_q);
							wr_data  <= LF_BYTE;
							state    <= W_CR;
						end
					end
					W_REC: begin
						wr_en    <= 1'b1;
						wr_addr  <= field_addr(cur_slot, byte_idx, six_q);
						wr_data  <= cur_field[byte_idx];
						byte_idx <= byte_idx + 2'd1;
						if (byte_idx == 2'd3)
							state <= W_WAIT;
					end
					W_CR: begin
						wr_en   <= 1'b1;
						wr_addr <= lf_addr(six_q) + buf_addr_t'(1);
						wr_data <= CR_BYTE;
						state   <= W_DONE;
					end
					W_DONE: begin
						done  <= 1'b1; // cycle after the cr write
						state <= W_IDLE;
					end
					default: state <= W_IDLE;
				endcase
				if (park) begin
					pend_valid <= 1'b1;
					pend_slot  <= slot;
					pend_field <= in_field;
				end
			end
		end
	end

endmodule

// ==== hw/track_buffer.sv ====
`timescale 1ns/1ps

module track_buffer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  clear,
	input  logic                  wr_en,
	input  tracker_pkg::buf_addr_t wr_addr,
	input  tracker_pkg::byte_t     wr_data,
	input  tracker_pkg::buf_addr_t buf_addr,
	output tracker_pkg::byte_t     buf_data
);
	import tracker_pkg::*;

	localparam int DEPTH = 2 ** $bits(buf_addr_t); // 64 bytes

	byte_t            mem [DEPTH];
	logic [DEPTH-1:0] valid; // written since last clear

	// storage write port
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// a write on the clear cycle keeps its flag
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else begin
			if (clear)
				valid <= '0;
			if (wr_en)
				valid[wr_addr] <= 1'b1;
		end
	end

	// consumer port with one cycle latency
	// unwritten bytes read as zero
	always_ff @(posedge clk) begin
		buf_data <= valid[buf_addr] ? mem[buf_addr] : '0;
	end

endmodule

// ==== hw/tracking_output_assembly.sv ====
`timescale 1ns/1ps

module tracking_output_assembly #(
	parameter int RANK_SIZE = 6,
	parameter int MAX_BLOBS = 19
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pause,       // freezes decode and execute
	input  logic                  start,
	input  logic                  six_color,
	input  tracker_pkg::ptr_addr_t valid_blobs,
	output tracker_pkg::ptr_addr_t ptr_addr,   // pointer table port
	input  tracker_pkg::ptr_t      ptr,
	output tracker_pkg::mem_addr_t mem_addr,   // main memory, read only
	input  tracker_pkg::word_t     mem_data,
	input  tracker_pkg::buf_addr_t buf_addr,   // consumer side
	output tracker_pkg::byte_t     buf_data,
	output logic                  done
);
	import tracker_pkg::*;

	// decode to execute
	logic  blob_valid;
	slot_t slot;
	byte_t x_byte;
	byte_t y_byte;
	byte_t size_hi;
	byte_t size_lo;
	logic  fetch_end;

	// execute to result
	logic      clear;
	logic      wr_en;
	buf_addr_t wr_addr;
	byte_t     wr_data;

	blob_fetch_decode #(
		.RANK_SIZE(RANK_SIZE),
		.MAX_BLOBS(MAX_BLOBS)
	) u_decode (
		.clk        (clk),
		.rst        (rst),
		.pause      (pause),
		.start      (start),
		.six_color  (six_color),
		.valid_blobs(valid_blobs),
		.ptr_addr   (ptr_addr),
		.ptr        (ptr),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.blob_valid (blob_valid),
		.slot       (slot),
		.x_byte     (x_byte),
		.y_byte     (y_byte),
		.size_hi    (size_hi),
		.size_lo    (size_lo),
		.fetch_end  (fetch_end)
	);

	record_writer #(
		.RANK_SIZE(RANK_SIZE)
	) u_writer (
		.clk       (clk),
		.rst       (rst),
		.pause     (pause),
		.start     (start),
		.six_color (six_color),
		.blob_valid(blob_valid),
		.slot      (slot),
		.x_byte    (x_byte),
		.y_byte    (y_byte),
		.size_hi   (size_hi),
		.size_lo   (size_lo),
		.fetch_end (fetch_end),
		.clear     (clear),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.done      (done)
	);

	track_buffer u_buffer (
		.clk     (clk),
		.rst     (rst),
		.clear   (clear),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.buf_addr(buf_addr),
		.buf_data(buf_data)
	);

endmodule

// ==== bench/tb_tracking_output_props.sv ====
`timescale 1ns/1ps

module tb_tracking_output_props (
	input logic                   clk,
	input logic                   rst,
	input logic                   pause,
	input logic                   done,
	input logic                   wr_en,
	input tracker_pkg::buf_addr_t wr_addr,
	input logic                   six_q,
	input logic                   blob_valid,
	input logic                   pend_valid
);
	int fail_count = 0; // failed assertions so far

	done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else begin
			fail_count++;
			$error("done high for more than one cycle");
		end

	// packet is 4 + 8n bytes
	write_in_packet: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> (int'(wr_addr) < 4 + 8 * (six_q ? 6 : 3)))
		else begin
			fail_count++;
			$error("write address %0d beyond the packet", wr_addr);
		end

	// one record in flight plus one parked at most
	no_overrun: assert property (@(posedge clk) disable iff (rst)
		(blob_valid && !pause) |-> !pend_valid)
		else begin
			fail_count++;
			$error("blob strobe while a record is already parked");
		end

endmodule

bind record_writer tb_tracking_output_props props0 (
	.clk       (clk),
	.rst       (rst),
	.pause     (pause),
	.done      (done),
	.wr_en     (wr_en),
	.wr_addr   (wr_addr),
	.six_q     (six_q),
	.blob_valid(blob_valid),
	.pend_valid(pend_valid)
);

// ==== bench/tb_tracking_output.sv ====
`timescale 1ns/1ps

module tb_tracking_output;
	import tracker_pkg::*;

	localparam int RANK_SIZE = 6;
	localparam int MAX_BLOBS = 19;
	localparam int TIMEOUT   = 2000; // cycles per wait

	logic      clk;
	logic      rst;
	logic      pause;
	logic      start;
	logic      six_color;
	ptr_addr_t valid_blobs;
	ptr_addr_t ptr_addr;
	ptr_t      ptr;
	mem_addr_t mem_addr;
	word_t     mem_data;
	buf_addr_t buf_addr;
	byte_t     buf_data;
	logic      done;

	ptr_t  ptr_table [32]; // pointer table model
	word_t main_mem [64];  // blob i at words 2i and 2i+1
	byte_t exp_img [64];   // expected packet
	int    errors;
	int    checks;
	int    done_count;
	logic  pause_on;       // random pause stretches enabled
	int    stretch;

	tracking_output_assembly #(
		.RANK_SIZE(RANK_SIZE),
		.MAX_BLOBS(MAX_BLOBS)
	) dut0 (
		.clk        (clk),
		.rst        (rst),
		.pause      (pause),
		.start      (start),
		.six_color  (six_color),
		.valid_blobs(valid_blobs),
		.ptr_addr   (ptr_addr),
		.ptr        (ptr),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.buf_addr   (buf_addr),
		.buf_data   (buf_data),
		.done       (done)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk; // 40 ns period

	// table and memory with one cycle latency each
	always @(posedge clk) begin
		ptr      <= ptr_table[ptr_addr];
		mem_data <= main_mem[mem_addr[5:0]];
	end

	always @(posedge clk) begin
		if (done)
			done_count++;
	end

	// pause toggles after a random number of cycles
	always @(posedge clk) begin
		#1;
		if (!pause_on) begin
			pause   = 1'b0;
			stretch = 0;
		end else if (stretch == 0) begin
			pause   = !pause;
			stretch = 1 + int'($urandom % 6);
		end else begin
			stretch = stretch - 1;
		end
	end

	// colour position in the mode's list or -1 if not stored
	function automatic int color_pos(color_t c, logic six);
		if (six)
			return (c <= COLOR_PURPLE) ? int'(c) : -1;
		case (c)
			COLOR_RED:   return 0;
			COLOR_GREEN: return 1;
			COLOR_BLUE:  return 2;
			default:     return -1;
		endcase
	endfunction

	task automatic fill_table();
		int    i;
		word_t w;
		for (i = 0; i < 32; i++) begin
			if (i < MAX_BLOBS)
				ptr_table[i] = ptr_t'(2 * i);
			else
				ptr_table[i] = PTR_END;
		end
		for (i = 0; i < 32; i++) begin
			w = $urandom;
			main_mem[2 * i]     = {w[31:8], color_t'(i % 6)}; // colours cycle r o y g b p
			main_mem[2 * i + 1] = $urandom;                   // x y size hi size lo
		end
	endtask

	// packet image from the layout rule
	task automatic build_expected(input logic six, input int count);
		int    i;
		int    n;
		int    c;
		int    k;
		word_t w;
		for (i = 0; i < 64; i++)
			exp_img[i] = '0;
		n = six ? 6 : 3;
		exp_img[0] = MARK_BYTE;
		exp_img[1] = six ? VERSION_SIX : VERSION_THREE;
		for (i = 0; i < count && i < MAX_BLOBS; i++) begin
			if (ptr_table[i] >= PTR_END)
				break; // end marker
			c = color_pos(main_mem[ptr_table[i][5:0]][7:0], six);
			if (i < 2 * RANK_SIZE && c >= 0) begin
				k = (i / RANK_SIZE) * n + c;
				w = main_mem[ptr_table[i][5:0] + 6'd1];
				exp_img[2 + 2 * k]         = w[31:24];
				exp_img[3 + 2 * k]         = w[23:16];
				exp_img[2 + 4 * n + 2 * k] = w[15:8];
				exp_img[3 + 4 * n + 2 * k] = w[7:0];
			end
		end
		exp_img[2 + 8 * n] = LF_BYTE;
		exp_img[3 + 8 * n] = CR_BYTE;
	endtask

	// start strobe then wait for done
	task automatic run_packet(input string name, input logic six, input int count,
			input logic with_pause);
		int   cyc;
		logic got;
		@(posedge clk);
		#1;
		start       = 1'b1;
		six_color   = six;
		valid_blobs = ptr_addr_t'(count);
		@(posedge clk);
		pause_on = with_pause; // start already taken
		#1;
		start = 1'b0;
		got   = 1'b0;
		for (cyc = 0; cyc < TIMEOUT && !got; cyc++) begin
			@(posedge clk);
			#1;
			got = done;
		end
		pause_on = 1'b0;
		checks++;
		assert (got) else begin
			$display("%s: no done within %0d cycles", name, TIMEOUT);
			errors++;
		end
		repeat (2) @(posedge clk); // pause back low
		#1;
	endtask

	// all 64 bytes through the consumer port
	task automatic check_buffer(input string name);
		int a;
		for (a = 0; a < 64; a++) begin
			buf_addr = buf_addr_t'(a);
			@(posedge clk);
			#1;
			checks++;
			assert (buf_data == exp_img[a]) else begin
				$display("mismatch %s addr %0d: expected %02h actual %02h",
					name, a, exp_img[a], buf_data);
				errors++;
			end
		end
	endtask

	task automatic idle_after_reset();
		int i;
		for (i = 0; i < 64; i++)
			exp_img[i] = '0;
		repeat (8) @(posedge clk);
		#1;
		check_buffer("reset_state");
		checks++;
		assert (done_count == 0) else begin
			$display("reset_state: done pulsed without a start");
			errors++;
		end
	endtask

	task automatic three_color_packet();
		fill_table();
		build_expected(1'b0, 12);
		run_packet("three_color", 1'b0, 12, 1'b0);
		check_buffer("three_color");
	endtask

	task automatic six_color_packet();
		fill_table();
		build_expected(1'b1, 12);
		run_packet("six_color", 1'b1, 12, 1'b0);
		check_buffer("six_color");
	endtask

	task automatic walk_end_cases();
		fill_table();
		build_expected(1'b1, 7); // stops at valid_blobs
		run_packet("walk_count", 1'b1, 7, 1'b0);
		check_buffer("walk_count");
		build_expected(1'b1, 19); // slots 12 and up dropped
		run_packet("walk_depth", 1'b1, 19, 1'b0);
		check_buffer("walk_depth");
		ptr_table[5] = PTR_END; // early end
		build_expected(1'b1, 19);
		run_packet("walk_marker", 1'b1, 19, 1'b0);
		check_buffer("walk_marker");
	endtask

	task automatic paused_packet();
		fill_table();
		build_expected(1'b1, 19);
		run_packet("pause", 1'b1, 19, 1'b1);
		check_buffer("pause");
	endtask

	task automatic stale_bytes_cleared();
		fill_table();
		run_packet("stale_first", 1'b1, 19, 1'b0); // six colour leaves bytes up to 51
		fill_table();
		build_expected(1'b0, 12);
		run_packet("stale_second", 1'b0, 12, 1'b0);
		check_buffer("stale_second");
	endtask

	initial begin
		void'($urandom(78702));
		errors      = 0;
		checks      = 0;
		done_count  = 0;
		pause_on    = 1'b0;
		stretch     = 0;
		rst         = 1'b1;
		pause       = 1'b0;
		start       = 1'b0;
		six_color   = 1'b0;
		valid_blobs = '0;
		buf_addr    = '0;
		ptr         <= '0;
		mem_data    <= '0;
		fill_table(); // no x on the model outputs
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		idle_after_reset();
		three_color_packet();
		six_color_packet();
		walk_end_cases();
		paused_packet();
		stale_bytes_cleared();
		errors = errors + dut0.u_writer.props0.fail_count; // bound assertions
		$display("errors %0d, assertion failures %0d, checks %0d",
			errors, dut0.u_writer.props0.fail_count, checks);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== tracking_output_assembly.f ====
hw/tracker_pkg.sv
hw/blob_fetch_decode.sv
hw/record_writer.sv
hw/track_buffer.sv
hw/tracking_output_assembly.sv
bench/tb_tracking_output_props.sv
bench/tb_tracking_output.sv

// ==== Makefile ====
TOP = tb_tracking_output
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f tracking_output_assembly.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "test did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
